//--- ahb_pkg.sv
`default_nettype none

package ahb_pkg;

    // bus widths
    parameter int ADDR_W = 32;
    parameter int DATA_W = 32;

    // cache line geometry
    parameter int LINE_WORDS = 4;
    parameter int LINE_W     = LINE_WORDS * DATA_W;

    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_e;

    // only WRAP4 is issued by the line-fill master
    typedef enum logic [2:0] {
        SINGLE = 3'b000,
        INCR   = 3'b001,
        WRAP4  = 3'b010,
        INCR4  = 3'b011
    } hburst_e;

    // line-fill master states
    typedef enum logic [1:0] {
        F_IDLE = 2'b00,
        F_ADDR = 2'b01,
        F_DATA = 2'b10,
        F_DONE = 2'b11
    } fill_state_e;

endpackage

`default_nettype wire

//--- ahb_bus.sv
`timescale 1ns/1ps
`default_nettype none

interface ahb_bus;

    // address phase
    logic [ahb_pkg::ADDR_W-1:0] haddr;
    ahb_pkg::htrans_e           htrans;
    ahb_pkg::hburst_e           hburst;
    logic                       hwrite;

    // data phase
    logic [ahb_pkg::DATA_W-1:0] hwdata;
    logic [ahb_pkg::DATA_W-1:0] hrdata;
    logic                       hready;

    modport master (
        output haddr,
        output htrans,
        output hburst,
        output hwrite,
        output hwdata,
        input  hrdata,
        input  hready
    );

    // slave ignores hburst, each beat is decoded on its own
    modport slave (
        input  haddr,
        input  htrans,
        input  hwrite,
        input  hwdata,
        output hrdata,
        output hready
    );

endinterface

`default_nettype wire

//--- ahb_transfer_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module ahb_transfer_decoder #(
    parameter int MEM_WORDS = 256
) (
    input  logic                         mem_intf,
    input  logic                         rst_n,
    input  logic [ahb_pkg::ADDR_W-1:0]   haddr,
    input  ahb_pkg::htrans_e             htrans,
    input  logic                         hwrite,
    input  logic                         hready,
    output logic                         xfer_active,
    output logic                         xfer_write,
    output logic [$clog2(MEM_WORDS)-1:0] word_index
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    logic [ahb_pkg::ADDR_W-3:0] word_addr;
    logic                       addr_valid;

    // byte lanes dropped, only word transfers are supported
    assign word_addr = haddr[ahb_pkg::ADDR_W-1:2];

    assign addr_valid = (htrans == ahb_pkg::NONSEQ) || (htrans == ahb_pkg::SEQ);

    // address phase sampled whenever the previous data phase ends
    always_ff @(posedge mem_intf or negedge rst_n) begin
        if (!rst_n) begin
            xfer_active <= 1'b0;
            xfer_write  <= 1'b0;
            word_index  <= '0;
        end else if (hready) begin
            xfer_active <= addr_valid;
            xfer_write  <= hwrite;
            // addresses beyond the memory wrap around
            word_index  <= IDX_W'(word_addr % MEM_WORDS);
        end
    end

endmodule

`default_nettype wire

//--- ahb_mem_slave.sv
`timescale 1ns/1ps
`default_nettype none

module ahb_mem_slave #(
    parameter int MEM_WORDS   = 256,
    parameter int WAIT_STATES = 2
) (
    input logic   mem_intf,
    input logic   rst_n,
    ahb_bus.slave bus
);

    localparam int IDX_W = $clog2(MEM_WORDS);
    localparam int DW    = ahb_pkg::DATA_W;
    localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

    logic [DW-1:0]    mem [MEM_WORDS];
    logic             xfer_active;
    logic             xfer_write;
    logic [IDX_W-1:0] word_index;
    logic [CNT_W-1:0] wait_cnt;
    logic             ready;
    logic             wr_en;

    ahb_transfer_decoder #(
        .MEM_WORDS (MEM_WORDS)
    ) i_decoder (
        .mem_intf    (mem_intf),
        .rst_n       (rst_n),
        .haddr       (bus.haddr),
        .htrans      (bus.htrans),
        .hwrite      (bus.hwrite),
        .hready      (ready),
        .xfer_active (xfer_active),
        .xfer_write  (xfer_write),
        .word_index  (word_index)
    );

    // data phase ends once the wait count is used up
    assign ready = !xfer_active || (wait_cnt == CNT_W'(WAIT_STATES));
    assign wr_en = xfer_active && xfer_write && ready;

    always_ff @(posedge mem_intf or negedge rst_n) begin
        if (!rst_n) begin
            wait_cnt <= '0;
        end else if (xfer_active && !ready) begin
            wait_cnt <= wait_cnt + 1'b1;
        end else begin
            wait_cnt <= '0;
        end
    end

    // each word starts out holding its own index
    always_ff @(posedge mem_intf or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < MEM_WORDS; k++) begin
                mem[k] <= DW'(k);
            end
        end else if (wr_en) begin
            mem[word_index] <= bus.hwdata;
        end
    end

    assign bus.hready = ready;

    // read data only shows in the completing cycle of a read
    assign bus.hrdata = (xfer_active && !xfer_write && ready) ? mem[word_index] : '0;

endmodule

`default_nettype wire

//--- line_fill_master.sv
`timescale 1ns/1ps
`default_nettype none

module line_fill_master (
    input  logic                         mem_intf,
    input  logic                         rst_n,
    input  logic                         req_valid,
    input  logic                         req_write,
    input  logic [ahb_pkg::ADDR_W-1:0]   req_addr,
    input  logic [ahb_pkg::LINE_W-1:0]   req_wdata,
    output logic                         busy,
    output logic                         done,
    output logic [ahb_pkg::LINE_W-1:0]   rdata,
    ahb_bus.master                       bus
);

    localparam int OFF_W = $clog2(ahb_pkg::LINE_WORDS);
    localparam int TAG_W = ahb_pkg::ADDR_W - OFF_W - 2;
    localparam int DW    = ahb_pkg::DATA_W;

    ahb_pkg::fill_state_e       state;
    logic [TAG_W-1:0]           line_addr;
    logic [OFF_W-1:0]           start_off;
    logic                       wr_q;
    logic [ahb_pkg::LINE_W-1:0] wdata_q;
    logic [OFF_W:0]             addr_cnt;
    logic [OFF_W-1:0]           data_cnt;
    logic [OFF_W-1:0]           addr_off;
    logic [OFF_W-1:0]           data_off;
    logic                       start;
    logic                       addr_phase;
    logic                       addr_taken;
    logic                       beat_done;
    logic                       last_beat;

    assign start = req_valid && (state == ahb_pkg::F_IDLE);

    // next address phase overlaps the data phase in flight
    assign addr_phase = (state == ahb_pkg::F_ADDR) ||
                        ((state == ahb_pkg::F_DATA) &&
                         (addr_cnt < (OFF_W + 1)'(ahb_pkg::LINE_WORDS)));
    assign addr_taken = addr_phase && bus.hready;
    assign beat_done  = (state == ahb_pkg::F_DATA) && bus.hready;
    assign last_beat  = (data_cnt == OFF_W'(ahb_pkg::LINE_WORDS - 1));

    // wrap the word offset inside the line
    assign addr_off = start_off + addr_cnt[OFF_W-1:0];
    assign data_off = start_off + data_cnt;

    always_ff @(posedge mem_intf or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ahb_pkg::F_IDLE;
            addr_cnt  <= '0;
            data_cnt  <= '0;
            wr_q      <= 1'b0;
            line_addr <= '0;
            start_off <= '0;
        end else begin
            case (state)
                ahb_pkg::F_IDLE: begin
                    if (start) begin
                        state     <= ahb_pkg::F_ADDR;
                        addr_cnt  <= '0;
                        data_cnt  <= '0;
                        wr_q      <= req_write;
                        line_addr <= req_addr[ahb_pkg::ADDR_W-1:OFF_W+2];
                        start_off <= req_addr[OFF_W+1:2];
                    end
                end
                ahb_pkg::F_ADDR: begin
                    if (addr_taken) begin
                        state <= ahb_pkg::F_DATA;
                    end
                end
                ahb_pkg::F_DATA: begin
                    if (beat_done && last_beat) begin
                        state <= ahb_pkg::F_DONE;
                    end
                end
                default: begin
                    state <= ahb_pkg::F_IDLE;
                end
            endcase
            if (addr_taken) begin
                addr_cnt <= addr_cnt + 1'b1;
            end
            if (beat_done) begin
                data_cnt <= data_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge mem_intf) begin
        if (start) begin
            wdata_q <= req_wdata;
        end
    end

    // read beats land at their line slot, not in arrival order
    always_ff @(posedge mem_intf) begin
        if (beat_done && !wr_q) begin
            rdata[data_off*DW +: DW] <= bus.hrdata;
        end
    end

    always_comb begin
        if (state == ahb_pkg::F_ADDR) begin
            bus.htrans = ahb_pkg::NONSEQ;
            bus.hburst = ahb_pkg::WRAP4;
        end else if (addr_phase) begin
            bus.htrans = ahb_pkg::SEQ;
            bus.hburst = ahb_pkg::WRAP4;
        end else begin
            bus.htrans = ahb_pkg::IDLE;
            bus.hburst = ahb_pkg::SINGLE;
        end
    end

    assign bus.haddr  = {line_addr, addr_off, 2'b00};
    assign bus.hwrite = wr_q;
    assign bus.hwdata = ((state == ahb_pkg::F_DATA) && wr_q) ? wdata_q[data_off*DW +: DW] : '0;

    assign busy = (state != ahb_pkg::F_IDLE);
    assign done = (state == ahb_pkg::F_DONE);

endmodule

`default_nettype wire

//--- mem_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top #(
    parameter int MEM_WORDS   = 256,
    parameter int WAIT_STATES = 2
) (
    input  logic                       mem_intf,
    input  logic                       rst_n,
    input  logic                       req_valid,
    input  logic                       req_write,
    input  logic [ahb_pkg::ADDR_W-1:0] req_addr,
    input  logic [ahb_pkg::LINE_W-1:0] req_wdata,
    output logic                       busy,
    output logic                       done,
    output logic [ahb_pkg::LINE_W-1:0] rdata
);

    ahb_bus i_bus ();

    line_fill_master i_master (
        .mem_intf  (mem_intf),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_write (req_write),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .busy      (busy),
        .done      (done),
        .rdata     (rdata),
        .bus       (i_bus.master)
    );

    ahb_mem_slave #(
        .MEM_WORDS   (MEM_WORDS),
        .WAIT_STATES (WAIT_STATES)
    ) i_slave (
        .mem_intf (mem_intf),
        .rst_n    (rst_n),
        .bus      (i_bus.slave)
    );

endmodule

`default_nettype wire

//--- tb_mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys;

    localparam int MEM_WORDS   = 256;
    localparam int WAIT_STATES = 2;
    localparam int LW          = ahb_pkg::LINE_W;
    localparam int DW          = ahb_pkg::DATA_W;
    localparam int LWORDS      = ahb_pkg::LINE_WORDS;
    localparam int SEED        = 77;
    localparam int DONE_LIMIT  = 100;
    localparam int QUIET_LIMIT = 40;
    localparam int RAND_LINES  = 20;

    logic          mem_intf;
    logic          rst_n;
    logic          req_valid;
    logic          req_write;
    logic [31:0]   req_addr;
    logic [LW-1:0] req_wdata;
    logic          busy;
    logic          done;
    logic [LW-1:0] rdata;

    // reference copy of the slave memory
    logic [DW-1:0] model [MEM_WORDS];
    int            test_errs;
    int            tests_passed;
    int            tests_failed;

    mem_subsys_top #(
        .MEM_WORDS   (MEM_WORDS),
        .WAIT_STATES (WAIT_STATES)
    ) i_mem_subsys_top (
        .mem_intf  (mem_intf),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_write (req_write),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .busy      (busy),
        .done      (done),
        .rdata     (rdata)
    );

    initial begin
        mem_intf = 1'b0;
        forever #5 mem_intf = ~mem_intf;
    end

    // first word of the line, after the memory wrap
    function automatic int line_base(logic [31:0] addr);
        int word;
        word = int'(addr[31:2] % 30'(MEM_WORDS));
        return (word / LWORDS) * LWORDS;
    endfunction

    function automatic logic [LW-1:0] expected_line(logic [31:0] addr);
        logic [LW-1:0] line;
        int            base;
        base = line_base(addr);
        for (int s = 0; s < LWORDS; s++) begin
            line[s*DW +: DW] = model[base + s];
        end
        return line;
    endfunction

    function automatic logic [LW-1:0] random_line();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    task automatic check_value(string name, logic [LW-1:0] exp, logic [LW-1:0] act);
        assert (act == exp) else begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            test_errs++;
        end
    endtask

    task automatic send_request(logic wr, logic [31:0] addr, logic [LW-1:0] wdata);
        @(posedge mem_intf);
        #1;
        req_valid = 1'b1;
        req_write = wr;
        req_addr  = addr;
        req_wdata = wdata;
        @(posedge mem_intf);
        #1;
        req_valid = 1'b0;
    endtask

    // counts cycles from the request edge to the edge that samples done
    task automatic wait_done(string name, output int cycles);
        cycles = 0;
        while (!done && cycles < DONE_LIMIT) begin
            @(negedge mem_intf);
            cycles++;
            if (!done) begin
                check_value({name, " busy"}, LW'(1), LW'(busy));
            end
        end
        if (!done) begin
            $display("%s timed out waiting for done", name);
            test_errs++;
        end
    endtask

    task automatic read_line(string name, logic [31:0] addr, output logic [LW-1:0] line,
                             output int cycles);
        send_request(1'b0, addr, '0);
        wait_done(name, cycles);
        line = rdata;
    endtask

    task automatic write_line(string name, logic [31:0] addr, logic [LW-1:0] wdata,
                              output int cycles);
        int base;
        base = line_base(addr);
        send_request(1'b1, addr, wdata);
        wait_done(name, cycles);
        for (int s = 0; s < LWORDS; s++) begin
            model[base + s] = wdata[s*DW +: DW];
        end
    endtask

    task automatic finish_test(string name);
        if (test_errs == 0) begin
            tests_passed++;
            $display("test %s passed", name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, test_errs);
        end
        test_errs = 0;
    endtask

    task automatic test_reset_read();
        logic [LW-1:0] line;
        int            cycles;
        check_value("reset busy", '0, LW'(busy));
        check_value("reset done", '0, LW'(done));
        read_line("reset_read", 32'h0, line, cycles);
        check_value("reset_read", {32'd3, 32'd2, 32'd1, 32'd0}, line);
        finish_test("reset_read");
    endtask

    task automatic test_wrap_read();
        logic [LW-1:0] aligned;
        logic [LW-1:0] wrapped;
        int            cycles;
        read_line("wrap_read", 32'h50, aligned, cycles);
        read_line("wrap_read", 32'h58, wrapped, cycles);
        check_value("wrap_read aligned", expected_line(32'h50), aligned);
        check_value("wrap_read word2", aligned, wrapped);
        finish_test("wrap_read");
    endtask

    task automatic test_write_read();
        logic [LW-1:0] wdata;
        logic [LW-1:0] line;
        int            cycles;
        wdata = random_line();
        write_line("write_read", 32'h90, wdata, cycles);
        read_line("write_read", 32'h94, line, cycles);
        check_value("write_read", wdata, line);
        read_line("write_read", 32'hA0, line, cycles);
        check_value("write_read neighbour", expected_line(32'hA0), line);
        finish_test("write_read");
    endtask

    task automatic test_latency();
        logic [LW-1:0] line;
        int            cycles;
        write_line("latency", 32'h144, random_line(), cycles);
        check_value("latency write", LW'(2 + 4 * (WAIT_STATES + 1)), LW'(cycles));
        @(negedge mem_intf);
        check_value("latency busy after write", '0, LW'(busy));
        read_line("latency", 32'h148, line, cycles);
        check_value("latency read", LW'(2 + 4 * (WAIT_STATES + 1)), LW'(cycles));
        @(negedge mem_intf);
        check_value("latency busy after read", '0, LW'(busy));
        finish_test("latency");
    endtask

    // a second strobe in the middle of a burst must be dropped
    task automatic test_ignored_request();
        logic [LW-1:0] wdata;
        logic [LW-1:0] line;
        int            cycles;
        int            quiet;
        wdata = random_line();
        send_request(1'b1, 32'h200, wdata);
        repeat (3) @(posedge mem_intf);
        #1;
        req_valid = 1'b1;
        req_addr  = 32'h300;
        req_wdata = random_line();
        @(posedge mem_intf);
        #1;
        req_valid = 1'b0;
        wait_done("ignored_request", cycles);
        for (int s = 0; s < LWORDS; s++) begin
            model[line_base(32'h200) + s] = wdata[s*DW +: DW];
        end
        quiet = 0;
        while (quiet < QUIET_LIMIT) begin
            @(negedge mem_intf);
            quiet++;
            check_value("ignored_request extra done", '0, LW'(done));
        end
        read_line("ignored_request", 32'h200, line, cycles);
        check_value("ignored_request first line", wdata, line);
        read_line("ignored_request", 32'h300, line, cycles);
        check_value("ignored_request second line", expected_line(32'h300), line);
        finish_test("ignored_request");
    endtask

    task automatic test_random_lines();
        logic [31:0]   addr;
        logic [31:0]   raddr;
        logic [31:0]   oaddr;
        logic [LW-1:0] wdata;
        logic [LW-1:0] line;
        int            cycles;
        for (int n = 0; n < RAND_LINES; n++) begin
            addr  = $urandom & 32'hFFFF_FFFC;
            // same line seen through an alias whole memory sizes away
            raddr = addr + 32'((n + 1) * MEM_WORDS * 4);
            raddr = {raddr[31:4], 2'($urandom), 2'b00};
            oaddr = $urandom & 32'hFFFF_FFFC;
            wdata = random_line();
            write_line("random_lines", addr, wdata, cycles);
            read_line("random_lines", raddr, line, cycles);
            check_value("random_lines data", wdata, line);
            read_line("random_lines", oaddr, line, cycles);
            check_value("random_lines model", expected_line(oaddr), line);
        end
        finish_test("random_lines");
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n        = 1'b0;
        req_valid    = 1'b0;
        req_write    = 1'b0;
        req_addr     = '0;
        req_wdata    = '0;
        test_errs    = 0;
        tests_passed = 0;
        tests_failed = 0;
        for (int k = 0; k < MEM_WORDS; k++) begin
            model[k] = DW'(k);
        end
        repeat (8) @(posedge mem_intf);
        #1;
        rst_n = 1'b1;
        test_reset_read();
        test_wrap_read();
        test_write_read();
        test_latency();
        test_ignored_request();
        test_random_lines();
        $display("tests passed %0d failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
ahb_pkg.sv
ahb_bus.sv
ahb_transfer_decoder.sv
ahb_mem_slave.sv
line_fill_master.sv
mem_subsys_top.sv
tb_mem_subsys.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_mem_subsys -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "STATUS: PASS"; then
    exit 0
fi
exit 1
